// File: Bender.yml
package:
  name: hazard_detect

sources:
  - src/hazardPkg.sv
  - src/stageWriterIf.sv
  - src/operandDecode.sv
  - src/operandHazard.sv
  - src/issueControl.sv
  - src/hazardDetect.sv
  - target: simulation
    files:
      - dv/hazardChecker.sv
      - dv/hazardTb.sv

// File: compile.f
src/hazardPkg.sv
src/stageWriterIf.sv
src/operandDecode.sv
src/operandHazard.sv
src/issueControl.sv
src/hazardDetect.sv
dv/hazardChecker.sv
dv/hazardTb.sv

// File: dv/hazardChecker.sv
// ************************************************
// output checker: compares the DUT outputs with the
// expected vector values and counts mismatches
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module hazardChecker import hazardPkg::*; (
    input  logic    clk,
    input  logic    checkEn,
    input  int      vecIdx,
    input  instT    nextInst,
    input  logic    pcNop,
    input  fwdCtrlT fwdCtrlA,
    input  fwdCtrlT fwdCtrlB,
    input  instT    expNextInst,
    input  logic    expPcNop,
    input  fwdCtrlT expFwdA,
    input  fwdCtrlT expFwdB,
    output int      errorCount
);

    initial errorCount = 0;

    // case inequality, so an X on an output also counts
    task automatic compareField(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("Mismatch vector %0d %s: got 0x%h expected 0x%h",
                     vecIdx, name, got, exp);
        end
    endtask

    // inputs move on the falling edge, so the rising edge sees settled outputs
    always @(posedge clk) begin
        if (checkEn) begin
            compareField("nextInst", nextInst, expNextInst);
            compareField("pcNop", {15'b0, pcNop}, {15'b0, expPcNop});
            compareField("fwdCtrlA", {10'b0, fwdCtrlA}, {10'b0, expFwdA});
            compareField("fwdCtrlB", {10'b0, fwdCtrlB}, {10'b0, expFwdB});
        end
    end

endmodule

`default_nettype wire

// File: dv/hazardPatterns.mem
// fetchInst  stages(D X M W: flags reg wbSel)  nextInst  pcNop  fwdCtrlA  fwdCtrlB
// flags digit: bit0 regWrt, bit1 branchInst; the first two vectors run in reset
8140 121000000000 0800 0 00 00 // reset with a load-use store
1000 200000000000 0800 0 00 00 // reset forces nop for siic too
8140 121000000000 0800 1 14 11 // st rd after load in D
DB80 132143000000 DB80 0 0A 0F // alu rs from D, rt from X
DDC0 000000150000 0800 1 04 04 // rs only in M stalls
DDC0 000152150000 DDC0 0 0E 06 // X match removes the stall
DDC0 000000000150 DDC0 0 04 04 // W match alone does nothing
C100 000200000000 0800 1 00 00 // lbi with branch in X
2345 000000130200 0800 1 00 00 // j with branch in W
1000 200000200000 1000 0 00 00 // siic passes branches
1800 301200000200 1800 0 00 00 // rti passes everything
C100 110000000000 C100 0 00 00 // lbi reads no register
8A60 122000000000 8A60 0 0A 20 // ld rs from D
8A60 132123000000 8A60 0 0F 20 // ld rs from X
8A60 121000000000 0800 1 01 20 // ld after load in D
99E0 112171000000 99E0 0 1A 1D // stu rs from D, rd from X
6400 000000140000 0800 1 04 00 // branch rs only in M
2C00 140000140000 2C00 0 08 00 // jr with D and M match
4600 161000000000 0800 1 01 00 // immediate form load-use

// File: dv/hazardTb.sv
// ************************************************
// testbench for the hazard detection unit: reads
// vectors from the pattern file and drives the DUT
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module hazardTb import hazardPkg::*; ();

    // six words per vector: fetch, stages, nextInst, pcNop, fwdA, fwdB
    localparam int WordsPerVec   = 6;
    localparam int MaxVectors    = 64;
    localparam int ResetCycles   = 2;
    localparam int TimeoutMargin = 10;

    logic    clk;
    logic    rstN;
    instT    fetchInst;
    logic    regWrtD;
    logic    regWrtX;
    logic    regWrtM;
    logic    regWrtW;
    regIdxT  wrtRegD;
    regIdxT  wrtRegX;
    regIdxT  wrtRegM;
    regIdxT  wrtRegW;
    wbSelE   wbDataSelD;
    wbSelE   wbDataSelX;
    logic    branchInstD;
    logic    branchInstX;
    logic    branchInstM;
    logic    branchInstW;
    instT    nextInst;
    logic    pcNop;
    fwdCtrlT fwdCtrlA;
    fwdCtrlT fwdCtrlB;

    // expected values, handed to the checker with each vector
    logic    checkEn;
    int      vecIdx;
    instT    expNextInst;
    logic    expPcNop;
    fwdCtrlT expFwdA;
    fwdCtrlT expFwdB;

    int checkErrors;
    int tbErrors;
    int numVectors;
    int cycleCount;
    int cycleLimit;

    logic [47:0] patMem [0:WordsPerVec*MaxVectors-1];

    hazardDetect hazardDetect_i (
        .clk        (clk),
        .rstN       (rstN),
        .fetchInst  (fetchInst),
        .regWrtD    (regWrtD),
        .regWrtX    (regWrtX),
        .regWrtM    (regWrtM),
        .regWrtW    (regWrtW),
        .wrtRegD    (wrtRegD),
        .wrtRegX    (wrtRegX),
        .wrtRegM    (wrtRegM),
        .wrtRegW    (wrtRegW),
        .wbDataSelD (wbDataSelD),
        .wbDataSelX (wbDataSelX),
        .branchInstD(branchInstD),
        .branchInstX(branchInstX),
        .branchInstM(branchInstM),
        .branchInstW(branchInstW),
        .nextInst   (nextInst),
        .pcNop      (pcNop),
        .fwdCtrlA   (fwdCtrlA),
        .fwdCtrlB   (fwdCtrlB)
    );

    hazardChecker outputCheck (
        .clk        (clk),
        .checkEn    (checkEn),
        .vecIdx     (vecIdx),
        .nextInst   (nextInst),
        .pcNop      (pcNop),
        .fwdCtrlA   (fwdCtrlA),
        .fwdCtrlB   (fwdCtrlB),
        .expNextInst(expNextInst),
        .expPcNop   (expPcNop),
        .expFwdA    (expFwdA),
        .expFwdB    (expFwdB),
        .errorCount (checkErrors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // vectors end at the first unloaded fetch word
    function automatic int countVectors();
        int  n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done && n < MaxVectors) begin
            if ($isunknown(patMem[n*WordsPerVec])) done = 1'b1;
            else n++;
        end
        return n;
    endfunction

    // unpack one vector; stage word is D X M W, 12 bits each
    task automatic applyVector(input int idx);
        int          base;
        logic [47:0] stageWord;
        base        = idx * WordsPerVec;
        stageWord   = patMem[base+1];
        fetchInst   = patMem[base][15:0];
        regWrtD     = stageWord[44];
        branchInstD = stageWord[45];
        wrtRegD     = stageWord[42:40];
        wbDataSelD  = wbSelE'(stageWord[37:36]);
        regWrtX     = stageWord[32];
        branchInstX = stageWord[33];
        wrtRegX     = stageWord[30:28];
        wbDataSelX  = wbSelE'(stageWord[25:24]);
        regWrtM     = stageWord[20];
        branchInstM = stageWord[21];
        wrtRegM     = stageWord[18:16];
        regWrtW     = stageWord[8];
        branchInstW = stageWord[9];
        wrtRegW     = stageWord[6:4];
        expNextInst = patMem[base+2][15:0];
        expPcNop    = patMem[base+3][0];
        expFwdA     = patMem[base+4][5:0];
        expFwdB     = patMem[base+5][5:0];
        vecIdx      = idx;
        checkEn     = 1'b1;
    endtask

    initial begin
        int i;
        int w;
        rstN        = 1'b0;
        fetchInst   = '0;
        regWrtD     = 1'b0;
        regWrtX     = 1'b0;
        regWrtM     = 1'b0;
        regWrtW     = 1'b0;
        wrtRegD     = '0;
        wrtRegX     = '0;
        wrtRegM     = '0;
        wrtRegW     = '0;
        wbDataSelD  = WbSlbi;
        wbDataSelX  = WbSlbi;
        branchInstD = 1'b0;
        branchInstX = 1'b0;
        branchInstM = 1'b0;
        branchInstW = 1'b0;
        checkEn     = 1'b0;
        vecIdx      = 0;
        expNextInst = '0;
        expPcNop    = 1'b0;
        expFwdA     = '0;
        expFwdB     = '0;
        tbErrors    = 0;
        cycleCount  = 0;
        $readmemh("dv/hazardPatterns.mem", patMem);
        numVectors = countVectors();
        if (numVectors == 0) begin
            tbErrors++;
            $display("no vectors could be read from the pattern file");
        end
        // a vector missing one of its words would be checked against junk
        for (i = 0; i < numVectors; i++) begin
            for (w = 1; w < WordsPerVec; w++) begin
                if ($isunknown(patMem[i*WordsPerVec+w])) begin
                    tbErrors++;
                    $display("vector %0d in the pattern file is incomplete", i);
                end
            end
        end
        cycleLimit = numVectors + TimeoutMargin;
        // first vectors run under reset, inputs change on the falling edge
        for (i = 0; i < numVectors; i++) begin
            @(negedge clk);
            rstN = (i >= ResetCycles);
            applyVector(i);
        end
        @(negedge clk);
        checkEn = 1'b0;
        $display("hazardTb: %0d vectors, %0d checker errors, %0d testbench errors",
                 numVectors, checkErrors, tbErrors);
        if (checkErrors == 0 && tbErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // cycle limit covers every vector plus a margin
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("hazardTb: %0d checker errors, %0d testbench errors",
                     checkErrors, tbErrors);
            $display("Simulation FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src/hazardDetect.sv
// ************************************************
// hazard detection unit between fetch and decode:
// bubble insertion, pc hold and operand forwarding
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module hazardDetect import hazardPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  instT    fetchInst,
    input  logic    regWrtD,
    input  logic    regWrtX,
    input  logic    regWrtM,
    input  logic    regWrtW,
    input  regIdxT  wrtRegD,
    input  regIdxT  wrtRegX,
    input  regIdxT  wrtRegM,
    input  regIdxT  wrtRegW,
    input  wbSelE   wbDataSelD,
    input  wbSelE   wbDataSelX,
    input  logic    branchInstD,
    input  logic    branchInstX,
    input  logic    branchInstM,
    input  logic    branchInstW,
    output instT    nextInst,
    output logic    pcNop,
    output fwdCtrlT fwdCtrlA,
    output fwdCtrlT fwdCtrlB
);

    logic    usesRs;
    logic    usesSrcB;
    logic    isStore;
    logic    isLoad;
    logic    isPassThru;
    logic    stallA;
    logic    stallB;
    fwdCtrlT fwdA;
    fwdCtrlT fwdB;

    stageWriterIf stgD ();
    stageWriterIf stgX ();
    stageWriterIf stgM ();
    stageWriterIf stgW ();

    // bundle the per-stage writer ports
    assign stgD.regWrt     = regWrtD;
    assign stgD.wrtReg     = wrtRegD;
    assign stgD.wbDataSel  = wbDataSelD;
    assign stgD.branchInst = branchInstD;
    assign stgX.regWrt     = regWrtX;
    assign stgX.wrtReg     = wrtRegX;
    assign stgX.wbDataSel  = wbDataSelX;
    assign stgX.branchInst = branchInstX;
    assign stgM.regWrt     = regWrtM;
    assign stgM.wrtReg     = wrtRegM;
    // M and W never supply a forwarding source
    assign stgM.wbDataSel  = WbSlbi;
    assign stgM.branchInst = branchInstM;
    assign stgW.regWrt     = regWrtW;
    assign stgW.wrtReg     = wrtRegW;
    assign stgW.wbDataSel  = WbSlbi;
    assign stgW.branchInst = branchInstW;

    operandDecode decode (
        .fetchInst (fetchInst),
        .usesRs    (usesRs),
        .usesSrcB  (usesSrcB),
        .isStore   (isStore),
        .isLoad    (isLoad),
        .isPassThru(isPassThru)
    );

    // operand A is rs
    operandHazard opA (
        .srcReg (fetchInst[RsHi:RsLo]),
        .used   (usesRs),
        .isStore(isStore),
        .isLoad (1'b0),
        .stgD   (stgD),
        .stgX   (stgX),
        .stgM   (stgM),
        .stall  (stallA),
        .fwd    (fwdA)
    );

    // operand B is rd for stores, rt for register forms
    operandHazard opB (
        .srcReg (fetchInst[SrcBHi:SrcBLo]),
        .used   (usesSrcB),
        .isStore(isStore),
        .isLoad (isLoad),
        .stgD   (stgD),
        .stgX   (stgX),
        .stgM   (stgM),
        .stall  (stallB),
        .fwd    (fwdB)
    );

    issueControl issue (
        .clk       (clk),
        .rstN      (rstN),
        .fetchInst (fetchInst),
        .stallA    (stallA),
        .stallB    (stallB),
        .isPassThru(isPassThru),
        .stgD      (stgD),
        .stgX      (stgX),
        .stgM      (stgM),
        .stgW      (stgW),
        .pcNop     (pcNop),
        .nextInst  (nextInst)
    );

    // no forwarding while the pipe is in reset
    assign fwdCtrlA = rstN ? fwdA : '0;
    assign fwdCtrlB = rstN ? fwdB : '0;

endmodule

`default_nettype wire

// File: src/hazardPkg.sv
// ************************************************
// hazard unit package: instruction fields, opcodes,
// bubble word and the forwarding word layout
// ************************************************
`default_nettype none

package hazardPkg;

    // datapath widths of the 16-bit, 8-register core
    localparam int InstWidth   = 16;
    localparam int RegIdxWidth = 3;
    localparam int OpcodeWidth = 5;
    localparam int FwdWidth    = 6;

    typedef logic [InstWidth-1:0]   instT;
    typedef logic [RegIdxWidth-1:0] regIdxT;
    typedef logic [OpcodeWidth-1:0] opcodeT;

    // writeback source of a producing stage, also the forwarding data source
    typedef enum logic [1:0] {
        WbSlbi = 2'd0,
        WbMem  = 2'd1,
        WbAlu  = 2'd2,
        WbImm8 = 2'd3
    } wbSelE;

    // forwarding word: ldFlag, stuSel, fwdEn, fromMem, srcSel[1:0]
    typedef logic [FwdWidth-1:0] fwdCtrlT;
    localparam int FwdLdBit  = 5;
    localparam int FwdStuBit = 4;
    localparam int FwdEnBit  = 3;
    localparam int FwdMemBit = 2;
    localparam int FwdSrcHi  = 1;
    localparam int FwdSrcLo  = 0;

    // instruction field positions
    localparam int OpHi   = 15;
    localparam int OpLo   = 11;
    localparam int RsHi   = 10;
    localparam int RsLo   = 8;
    // rd for stores, rt for register alu forms
    localparam int SrcBHi = 7;
    localparam int SrcBLo = 5;

    // single opcodes
    localparam opcodeT OpSt   = 5'b10000;
    localparam opcodeT OpStu  = 5'b10011;
    localparam opcodeT OpLd   = 5'b10001;
    localparam opcodeT OpAlu  = 5'b11011;
    localparam opcodeT OpBit  = 5'b11010;
    localparam opcodeT OpLbi  = 5'b11000;
    localparam opcodeT OpHalt = 5'b00000;
    localparam opcodeT OpNop  = 5'b00001;
    localparam opcodeT OpSiic = 5'b00010;
    localparam opcodeT OpRti  = 5'b00011;

    // opcode groups, matched as (op & mask) == val
    localparam opcodeT OpSetVal     = 5'b11100;
    localparam opcodeT OpSetMask    = 5'b11100;
    localparam opcodeT OpBranchVal  = 5'b01100;
    localparam opcodeT OpBranchMask = 5'b11100;
    localparam opcodeT OpJmpRegVal  = 5'b00101;
    localparam opcodeT OpJmpRegMask = 5'b11101;
    localparam opcodeT OpJmpVal     = 5'b00100;
    localparam opcodeT OpJmpMask    = 5'b11101;

    // bubble issued on stall or reset
    localparam instT NopInst = {OpNop, {(InstWidth-OpcodeWidth){1'b0}}};

endpackage

`default_nettype wire

// File: src/issueControl.sv
// ************************************************
// issue logic: pc hold and bubble insertion
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module issueControl import hazardPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  instT       fetchInst,
    input  logic       stallA,
    input  logic       stallB,
    input  logic       isPassThru,
    stageWriterIf.sink stgD,
    stageWriterIf.sink stgX,
    stageWriterIf.sink stgM,
    stageWriterIf.sink stgW,
    output logic       pcNop,
    output instT       nextInst
);

    logic anyBranch;
    logic anyStall;

    // hold fetch while any branch is unresolved down the pipe
    assign anyBranch = stgD.branchInst || stgX.branchInst ||
                       stgM.branchInst || stgW.branchInst;
    assign anyStall  = stallA || stallB;

    // siic and rti never hold the pc
    assign pcNop = rstN && !isPassThru && (anyStall || anyBranch);

    // bubble on hold, and for every opcode while in reset
    assign nextInst = (pcNop || !rstN) ? NopInst : fetchInst;

    // a held pc must never let the fetched word into decode
    pcNopIssuesBubble: assert property (@(posedge clk) disable iff (!rstN)
        pcNop |-> (nextInst == NopInst))
        else $error("issueControl: pcNop set but nextInst is %h", nextInst);

endmodule

`default_nettype wire

// File: src/operandDecode.sv
// ************************************************
// opcode decode into operand-use classes for the
// fetched instruction
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module operandDecode import hazardPkg::*; (
    input  instT fetchInst,
    output logic usesRs,
    output logic usesSrcB,
    output logic isStore,
    output logic isLoad,
    output logic isPassThru
);

    opcodeT op;

    assign op = fetchInst[OpHi:OpLo];

    // priority match, same order as the original case list
    always_comb begin
        usesRs     = 1'b0;
        usesSrcB   = 1'b0;
        isStore    = 1'b0;
        isLoad     = 1'b0;
        isPassThru = 1'b0;
        if (op == OpSt || op == OpStu) begin
            // stores read rs for the address and rd for the data
            usesRs   = 1'b1;
            usesSrcB = 1'b1;
            isStore  = 1'b1;
        end else if (op == OpAlu || op == OpBit ||
                     (op & OpSetMask) == OpSetVal) begin
            // register forms read rs and rt
            usesRs   = 1'b1;
            usesSrcB = 1'b1;
        end else if (op == OpLbi || op == OpHalt || op == OpNop) begin
            // no register read at all
            usesRs = 1'b0;
        end else if (op == OpSiic || op == OpRti) begin
            // exception entry and return go straight through
            isPassThru = 1'b1;
        end else if ((op & OpBranchMask) == OpBranchVal ||
                     (op & OpJmpRegMask) == OpJmpRegVal) begin
            // branches and jr/jalr compare or add rs only
            usesRs = 1'b1;
        end else if ((op & OpJmpMask) == OpJmpVal) begin
            // j and jal use a pc displacement only
            usesRs = 1'b0;
        end else begin
            // immediate and load forms read rs
            usesRs = 1'b1;
            isLoad = (op == OpLd);
        end
    end

    // a pass-through opcode must never be held for an rs hazard
    passThruNoRead: assert #0 (!(isPassThru && usesRs))
        else $error("operandDecode: pass-through opcode %b marked as rs reader", op);

endmodule

`default_nettype wire

// File: src/operandHazard.sv
// ************************************************
// per-operand stage match, stall and forwarding word
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module operandHazard import hazardPkg::*; (
    input  regIdxT            srcReg,
    input  logic              used,
    input  logic              isStore,
    input  logic              isLoad,
    stageWriterIf.sink        stgD,
    stageWriterIf.sink        stgX,
    stageWriterIf.sink        stgM,
    output logic              stall,
    output fwdCtrlT           fwd
);

    logic matchD;
    logic matchX;
    logic matchM;
    logic loadD;
    logic mOnly;

    // a stage matches when it writes the register this operand reads
    assign matchD = stgD.regWrt && (stgD.wrtReg == srcReg);
    assign matchX = stgX.regWrt && (stgX.wrtReg == srcReg);
    assign matchM = stgM.regWrt && (stgM.wrtReg == srcReg);

    // load result is not ready for ex-to-ex forwarding
    assign loadD = matchD && (stgD.wbDataSel == WbMem);

    // value only in M has no forwarding path, wait one cycle
    // a younger writer in D or X holds the newer value
    assign mOnly = matchM && !matchX && !matchD;

    always_comb begin
        stall = 1'b0;
        fwd   = '0;
        // load flag marks the instruction, so it is kept for unused operands
        fwd[FwdLdBit] = isLoad;
        if (used) begin
            stall          = mOnly || loadD;
            fwd[FwdStuBit] = isStore;
            // forward from the nearest writer unless it is a load in D
            fwd[FwdEnBit]  = (matchD || matchX) && !loadD;
            // D match means ex-to-ex, otherwise mem-to-ex
            fwd[FwdMemBit] = !matchD;
            // data source follows the stage the value comes from
            fwd[FwdSrcHi:FwdSrcLo] = matchD ? stgD.wbDataSel : stgX.wbDataSel;
        end
    end

    // a stalled operand must not also claim a forwarding path
    stallNoFwd: assert #0 (!(stall && fwd[FwdEnBit]))
        else $error("operandHazard: stall and fwdEn both set for r%0d", srcReg);

endmodule

`default_nettype wire

// File: src/stageWriterIf.sv
// ************************************************
// register-write and branch info of one pipe stage
// ************************************************
`timescale 1ns/1ps
`default_nettype none

interface stageWriterIf import hazardPkg::*; ();

    // stage will write the register file
    logic   regWrt;
    // destination register of that write
    regIdxT wrtReg;
    // where the written value comes from
    wbSelE  wbDataSel;
    // stage holds a branch or jump not yet resolved
    logic   branchInst;

    // driven by the top level from the pipeline ports
    modport src (
        output regWrt,
        output wrtReg,
        output wbDataSel,
        output branchInst
    );

    // read by the hazard checks and the issue logic
    modport sink (
        input regWrt,
        input wrtReg,
        input wbDataSel,
        input branchInst
    );

endinterface

`default_nettype wire
